// ==== files.f ====
+incdir+.
video_pkg.sv
ping_pong_fifo.sv
pixel_reader.sv
video_timing_gen.sv
video_out_top.sv
video_out_checker.sv
tb_video_out.sv

// ==== ping_pong_fifo.sv ====
// writer holds one i_wr_act bit at a time; words past o_wr_size in one bank are dropped
`timescale 1ns/1ps
`include "video_config.svh"

module ping_pong_fifo (
  input  logic                  clk,
  input  logic                  rst,

  // writer side, one bank at a time
  output logic [1:0]            o_wr_rdy,
  input  logic [1:0]            i_wr_act,
  input  logic                  i_wr_stb,
  input  video_pkg::rgb_pixel_t i_wr_data,
  output logic [`VID_FIFO_AW:0] o_wr_size,

  // reader side, bank granular
  output logic                  o_rd_rdy,
  input  logic                  i_rd_act,
  input  logic                  i_rd_stb,
  output logic [`VID_FIFO_AW:0] o_rd_size,
  output video_pkg::rgb_pixel_t o_rd_data
);

  localparam int DEPTH = 1 << `VID_FIFO_AW;

  typedef enum logic [1:0] {
    ST_EMPTY,
    ST_WRITING,
    ST_FULL,
    ST_READING
  } bank_state_t;

  bank_state_t             state [2];
  logic [`VID_FIFO_AW:0]   fill [2];
  logic [`VID_FIFO_AW-1:0] rd_ptr;
  // bank offered to the reader, always the oldest committed one
  logic                    rd_bank;
  video_pkg::rgb_pixel_t   mem [2][DEPTH];

  logic [1:0]              wr_en;
  logic [1:0]              commit;
  logic                    rd_claim;
  logic                    rd_release;

  // write strobe lands in the bank whose act bit is up
  // also accepted in the cycle act first rises
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      wr_en[b]  = i_wr_act[b] && i_wr_stb &&
                  (state[b] == ST_EMPTY || state[b] == ST_WRITING) &&
                  (fill[b] < DEPTH);
      commit[b] = (state[b] == ST_WRITING) && !i_wr_act[b];
    end
  end

  assign rd_claim   = (state[rd_bank] == ST_FULL) && i_rd_act;
  assign rd_release = (state[rd_bank] == ST_READING) && !i_rd_act;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < 2; b++) begin
        state[b] <= ST_EMPTY;
        fill[b]  <= '0;
      end
      rd_bank <= 1'b0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        case (state[b])
          ST_EMPTY: begin
            if (i_wr_act[b]) begin
              state[b] <= ST_WRITING;
            end
          end
          ST_WRITING: begin
            // an empty commit just hands the bank back
            if (commit[b]) begin
              state[b] <= (fill[b] == 0) ? ST_EMPTY : ST_FULL;
            end
          end
          ST_FULL: begin
            if (rd_claim && (rd_bank == b[0])) begin
              state[b] <= ST_READING;
            end
          end
          default: begin
            if (rd_release && (rd_bank == b[0])) begin
              state[b] <= ST_EMPTY;
              fill[b]  <= '0;
            end
          end
        endcase

        if (wr_en[b]) begin
          fill[b] <= fill[b] + 1'b1;
        end

        // first committed bank becomes the read target
        // otherwise it waits behind the other one
        if (commit[b] && (fill[b] != 0) &&
            (state[1-b] != ST_FULL) && (state[1-b] != ST_READING)) begin
          rd_bank <= b[0];
        end
      end

      // done with this bank, the other one is next in line
      if (rd_release) begin
        rd_bank <= ~rd_bank;
      end
    end
  end

  // read pointer is shared, only one bank is read at a time
  // must sit at zero before the claim cycle, reader may strobe then
  always_ff @(posedge clk) begin
    if (rst || rd_release) begin
      rd_ptr <= '0;
    end else if (i_rd_stb) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // bank storage
  always_ff @(posedge clk) begin
    for (int b = 0; b < 2; b++) begin
      if (wr_en[b]) begin
        mem[b][fill[b][`VID_FIFO_AW-1:0]] <= i_wr_data;
      end
    end
  end

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      o_wr_rdy[b] = (state[b] == ST_EMPTY);
    end
  end

  assign o_wr_size = (`VID_FIFO_AW+1)'(DEPTH);

  // show-ahead read port
  assign o_rd_rdy  = (state[rd_bank] == ST_FULL);
  assign o_rd_size = fill[rd_bank];
  assign o_rd_data = mem[rd_bank][rd_ptr];

endmodule

// ==== pixel_reader.sv ====
// o_rd_stb is combinational from i_pix_stb; pattern commands are taken only while idle
`timescale 1ns/1ps
`include "video_config.svh"

module pixel_reader (
  input  logic                  clk,
  input  logic                  rst,

  // fifo read side
  input  logic                  i_rd_rdy,
  output logic                  o_rd_act,
  input  logic [`VID_FIFO_AW:0] i_rd_size,
  input  video_pkg::rgb_pixel_t i_rd_data,
  output logic                  o_rd_stb,

  // pixel link to the timing generator
  output video_pkg::rgb_pixel_t o_pix,
  output logic                  o_pix_rdy,
  input  logic                  i_pix_stb,

  // test pattern command
  input  logic                  i_tp_valid,
  input  video_pkg::tp_cmd_t    i_tp_cmd,
  output logic                  o_tp_busy
);

  logic [`VID_FIFO_AW:0]   rd_count;
  logic                    tp_active;
  logic [`VID_CNT_W-1:0]   tp_left;
  video_pkg::rgb_pixel_t   tp_pixel;
  logic                    idle;
  logic                    tp_accept;
  logic                    rd_load;

  // solid colour, full scale on enabled channels
  always_comb begin
    tp_pixel = '0;
    if (i_tp_cmd.red_en) begin
      tp_pixel.red = '1;
    end
    if (i_tp_cmd.green_en) begin
      tp_pixel.green = '1;
    end
    if (i_tp_cmd.blue_en) begin
      tp_pixel.blue = '1;
    end
  end

  // nothing claimed, nothing pending on the link
  assign idle      = !o_rd_act && !o_pix_rdy && !tp_active;
  assign o_tp_busy = !idle;
  // zero length command does nothing
  assign tp_accept = idle && i_tp_valid && (i_tp_cmd.count != 0);

  // fetch when the holding register is free or is being consumed now
  assign rd_load  = o_rd_act && !tp_active && (rd_count < i_rd_size) &&
                    (!o_pix_rdy || i_pix_stb);
  // strobe advances the fifo pointer on the same edge as the load
  assign o_rd_stb = rd_load;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_rd_act  <= 1'b0;
      o_pix_rdy <= 1'b0;
      rd_count  <= '0;
      tp_active <= 1'b0;
      tp_left   <= '0;
    end else if (tp_accept) begin
      tp_active <= 1'b1;
      tp_left   <= i_tp_cmd.count;
      o_pix_rdy <= 1'b1;
    end else if (tp_active) begin
      // pattern mode, count consumed pixels down
      if (i_pix_stb) begin
        tp_left <= tp_left - 1'b1;
        if (tp_left == 1) begin
          tp_active <= 1'b0;
          o_pix_rdy <= 1'b0;
        end
      end
    end else begin
      // claim a bank, may overlap the last pixel of the previous one
      if (!o_rd_act && i_rd_rdy) begin
        o_rd_act <= 1'b1;
        rd_count <= '0;
      end

      if (rd_load) begin
        rd_count  <= rd_count + 1'b1;
        o_pix_rdy <= 1'b1;
        // last word taken, free the bank right away
        if (rd_count + 1'b1 == i_rd_size) begin
          o_rd_act <= 1'b0;
        end
      end else if (i_pix_stb) begin
        o_pix_rdy <= 1'b0;
      end
    end
  end

  // held pixel
  always_ff @(posedge clk) begin
    if (tp_accept) begin
      o_pix <= tp_pixel;
    end else if (rd_load) begin
      o_pix <= i_rd_data;
    end
  end

endmodule

// ==== tb_video_out.sv ====
// needs the default raster macros; written pixels are never black since black marks a starved position
`timescale 1ns/1ps
`include "video_config.svh"

module tb_video_out;

  localparam int LIMIT = 400;
  localparam int LINE  = `VID_H_ACTIVE + `VID_H_BLANK;

  logic                  clk;
  logic                  rst;
  logic [1:0]            wr_rdy;
  logic [1:0]            wr_act;
  logic                  wr_stb;
  video_pkg::rgb_pixel_t wr_data;
  logic [`VID_FIFO_AW:0] wr_size;
  logic                  tp_valid;
  video_pkg::tp_cmd_t    tp_cmd;
  logic                  tp_busy;
  video_pkg::rgb_pixel_t pixel;
  logic                  de;
  logic                  hsync;
  logic                  vsync;
  logic                  underflow;

  // expected pixel stream in write order
  video_pkg::rgb_pixel_t exp_q [$];
  video_pkg::rgb_pixel_t exp_px;
  int                    errors = 0;
  string                 test_name = "reset";

  video_out_top video_out_top_inst (
    .clk         (clk),
    .rst         (rst),
    .o_wr_rdy    (wr_rdy),
    .i_wr_act    (wr_act),
    .i_wr_stb    (wr_stb),
    .i_wr_data   (wr_data),
    .o_wr_size   (wr_size),
    .i_tp_valid  (tp_valid),
    .i_tp_cmd    (tp_cmd),
    .o_tp_busy   (tp_busy),
    .o_pixel     (pixel),
    .o_de        (de),
    .o_hsync     (hsync),
    .o_vsync     (vsync),
    .o_underflow (underflow)
  );

  always #20 clk = ~clk;

  function automatic int unsigned checker_failures();
    return video_out_top_inst.video_out_checker_inst.fail_count;
  endfunction

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    $display("errors: scoreboard %0d, assertions %0d", errors, checker_failures());
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // zero is reserved for starved positions
  function automatic video_pkg::rgb_pixel_t rand_pixel();
    logic [`VID_PIXEL_W-1:0] v;
    v = $urandom;
    while (v == '0) begin
      v = $urandom;
    end
    return video_pkg::rgb_pixel_t'(v);
  endfunction

  task automatic wait_vsync_rise();
    int n;
    n = 0;
    while (vsync && n < LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (vsync) begin
      timeout_fail("vsync low");
    end
    n = 0;
    while (!vsync && n < LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!vsync) begin
      timeout_fail("vsync high");
    end
  endtask

  // fills one bank with the first word on the act edge and commits by dropping act
  task automatic write_bank(input int words);
    int n;
    int b;
    video_pkg::rgb_pixel_t px;
    n = 0;
    while (wr_rdy == 2'b00 && n < LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (wr_rdy == 2'b00) begin
      timeout_fail("a free fifo bank");
    end
    b = wr_rdy[0] ? 0 : 1;
    wr_act[b] = 1'b1;
    for (int i = 0; i < words; i++) begin
      px = rand_pixel();
      exp_q.push_back(px);
      wr_stb  = 1'b1;
      wr_data = px;
      @(posedge clk);
      #2;
    end
    wr_stb = 1'b0;
    wr_act = 2'b00;
    @(posedge clk);
    #2;
  endtask

  // all expected pixels shown and the reader back to idle
  task automatic wait_until_idle();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || tp_busy) && n < LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (exp_q.size() != 0 || tp_busy) begin
      timeout_fail("the pixel stream to drain");
    end
  endtask

  // scoreboard samples the outputs mid cycle
  always @(negedge clk) begin
    if (!rst && !de) begin
      assert (pixel == '0) else begin
        errors++;
        $display("[ERROR] %s: blank pixel expected %h actual %h", test_name, 24'h0, pixel);
      end
    end else if (!rst && pixel == '0) begin
      assert (underflow) else begin
        errors++;
        $display("black pixel on an enabled cycle with underflow low in %s", test_name);
      end
    end else if (!rst) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("pixel %h shown with nothing left to expect in %s", pixel, test_name);
      end
      if (exp_q.size() != 0) begin
        exp_px = exp_q.pop_front();
        assert (pixel == exp_px) else begin
          errors++;
          $display("[ERROR] %s: pixel expected %h actual %h", test_name, exp_px, pixel);
        end
      end
    end
  end

  initial begin
    void'($urandom(54));
    clk      = 1'b0;
    rst      = 1'b1;
    wr_act   = 2'b00;
    wr_stb   = 1'b0;
    wr_data  = '0;
    tp_valid = 1'b0;
    tp_cmd   = '0;
    repeat (10) begin
      @(posedge clk);
    end
    #2;
    rst = 1'b0;

    // eight words per bank as seen by the writer
    assert (wr_size == 8) else begin
      errors++;
      $display("[ERROR] %s: wr_size expected %0d actual %0d", test_name, 8, wr_size);
    end

    // first frame has no data at all
    test_name = "no_data";
    wait_vsync_rise();
    assert (underflow) else begin
      errors++;
      $display("[ERROR] %s: underflow expected 1 actual %b", test_name, underflow);
    end

    // writing starts in vertical blank so banks line up with lines
    test_name = "stream";
    fork
      begin : writer
        for (int k = 0; k < 10; k++) begin
          write_bank(8);
        end
      end
      begin : raster_watch
        int n;
        wait_vsync_rise();
        assert (!underflow) else begin
          errors++;
          $display("[ERROR] %s: underflow expected 0 actual %b", test_name, underflow);
        end
        // writer runs ahead of the raster here and takes both banks
        n = 0;
        while (wr_rdy != 2'b00 && n < LINE * `VID_V_BLANK) begin
          @(posedge clk);
          #2;
          n++;
        end
        assert (wr_rdy == 2'b00) else begin
          errors++;
          $display("[ERROR] %s: wr_rdy expected 00 actual %b", test_name, wr_rdy);
        end
      end
    join
    wait_until_idle();

    // red and blue at full scale with green off
    test_name       = "pattern";
    tp_cmd.red_en   = 1'b1;
    tp_cmd.green_en = 1'b0;
    tp_cmd.blue_en  = 1'b1;
    tp_cmd.count    = 5;
    tp_valid        = 1'b1;
    for (int k = 0; k < 5; k++) begin
      exp_q.push_back(video_pkg::rgb_pixel_t'(24'hFF00FF));
    end
    @(posedge clk);
    #2;
    assert (tp_busy) else begin
      errors++;
      $display("[ERROR] %s: tp_busy expected 1 actual %b", test_name, tp_busy);
    end
    // green command while busy gets dropped by the reader
    tp_cmd.red_en   = 1'b0;
    tp_cmd.green_en = 1'b1;
    tp_cmd.blue_en  = 1'b0;
    tp_cmd.count    = 3;
    @(posedge clk);
    #2;
    tp_valid = 1'b0;
    write_bank(8);
    write_bank(8);
    wait_until_idle();
    repeat (2 * LINE) begin
      @(posedge clk);
    end

    $display("errors: scoreboard %0d, assertions %0d", errors, checker_failures());
    if (errors == 0 && checker_failures() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== video_config.svh ====
// single clock domain; raster has no porches and the sizes are fixed at build time
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// rgb word, three 8 bit channels
`define VID_PIXEL_W 24

// log2 of words per fifo bank
`define VID_FIFO_AW 3

// horizontal raster, in clock cycles
`define VID_H_ACTIVE 8
`define VID_H_BLANK 4
`define VID_HSYNC_W 2

// vertical raster, in lines
`define VID_V_ACTIVE 4
`define VID_V_BLANK 2

// pixel count and raster counter width
`define VID_CNT_W 16

`endif

// ==== video_out_checker.sv ====
// bound into video_out_top; raster run lengths are counted in VID_CNT_W bits
`timescale 1ns/1ps
`include "video_config.svh"

module video_out_checker (
  input logic                  clk,
  input logic                  rst,
  input logic [1:0]            i_wr_rdy,
  input logic                  i_tp_busy,
  input logic                  i_pix_stb,
  input video_pkg::rgb_pixel_t i_pixel,
  input logic                  i_de,
  input logic                  i_hsync,
  input logic                  i_vsync,
  input logic                  i_underflow
);

  int unsigned           fail_count = 0;
  logic [`VID_CNT_W-1:0] de_run;
  logic [`VID_CNT_W-1:0] hs_run;
  logic [`VID_CNT_W-1:0] vs_run;

  task automatic record_failure(input string what);
    fail_count++;
    $error("%s", what);
  endtask

  // consecutive high cycles, value at a falling edge is the full run
  always_ff @(posedge clk) begin
    if (rst) begin
      de_run <= '0;
      hs_run <= '0;
      vs_run <= '0;
    end else begin
      de_run <= i_de ? de_run + 1'b1 : '0;
      hs_run <= i_hsync ? hs_run + 1'b1 : '0;
      vs_run <= i_vsync ? vs_run + 1'b1 : '0;
    end
  end

  // every control output idle right after a reset cycle
  a_reset_idle: assert property (@(posedge clk)
    rst |=> (i_wr_rdy == 2'b11) && !i_de && !i_hsync && !i_vsync && !i_underflow && !i_tp_busy)
    else record_failure("control outputs not idle after reset");

  a_de_run: assert property (@(posedge clk) disable iff (rst)
    $fell(i_de) |-> (de_run == `VID_H_ACTIVE))
    else record_failure("enable run is not one active line long");

  // hsync opens the horizontal blank
  a_hsync_start: assert property (@(posedge clk) disable iff (rst)
    $fell(i_de) |-> i_hsync)
    else record_failure("hsync missing right after the active run");

  a_hsync_run: assert property (@(posedge clk) disable iff (rst)
    $fell(i_hsync) |-> (hs_run == `VID_HSYNC_W))
    else record_failure("hsync pulse has the wrong width");

  a_vsync_run: assert property (@(posedge clk) disable iff (rst)
    $fell(i_vsync) |-> (vs_run == `VID_V_BLANK * (`VID_H_ACTIVE + `VID_H_BLANK)))
    else record_failure("vsync is not the vertical blank length");

  a_de_vsync: assert property (@(posedge clk) disable iff (rst)
    !(i_de && i_vsync))
    else record_failure("enable high during vsync");

  // enabled position that pulled nothing, black and flagged
  a_starve: assert property (@(posedge clk) disable iff (rst)
    (i_de && !$past(i_pix_stb)) |-> (i_pixel == '0) && i_underflow)
    else record_failure("starved position not black or not flagged");

endmodule

bind video_out_top video_out_checker video_out_checker_inst (
  .clk         (clk),
  .rst         (rst),
  .i_wr_rdy    (o_wr_rdy),
  .i_tp_busy   (o_tp_busy),
  .i_pix_stb   (pix_stb),
  .i_pixel     (o_pixel),
  .i_de        (o_de),
  .i_hsync     (o_hsync),
  .i_vsync     (o_vsync),
  .i_underflow (o_underflow)
);

// ==== video_out_top.sv ====
// whole path on clk; pixel latency from a committed bank depends on raster position
`timescale 1ns/1ps
`include "video_config.svh"

module video_out_top (
  input  logic                  clk,
  input  logic                  rst,

  // writer side of the fifo
  output logic [1:0]            o_wr_rdy,
  input  logic [1:0]            i_wr_act,
  input  logic                  i_wr_stb,
  input  video_pkg::rgb_pixel_t i_wr_data,
  output logic [`VID_FIFO_AW:0] o_wr_size,

  // test pattern
  input  logic                  i_tp_valid,
  input  video_pkg::tp_cmd_t    i_tp_cmd,
  output logic                  o_tp_busy,

  // video out
  output video_pkg::rgb_pixel_t o_pixel,
  output logic                  o_de,
  output logic                  o_hsync,
  output logic                  o_vsync,
  output logic                  o_underflow
);

  // fifo to reader
  logic                  rd_rdy;
  logic                  rd_act;
  logic                  rd_stb;
  logic [`VID_FIFO_AW:0] rd_size;
  video_pkg::rgb_pixel_t rd_data;

  // reader to timing
  video_pkg::rgb_pixel_t pix;
  logic                  pix_rdy;
  logic                  pix_stb;

  ping_pong_fifo ping_pong_fifo_inst (
    .clk       (clk),
    .rst       (rst),
    .o_wr_rdy  (o_wr_rdy),
    .i_wr_act  (i_wr_act),
    .i_wr_stb  (i_wr_stb),
    .i_wr_data (i_wr_data),
    .o_wr_size (o_wr_size),
    .o_rd_rdy  (rd_rdy),
    .i_rd_act  (rd_act),
    .i_rd_stb  (rd_stb),
    .o_rd_size (rd_size),
    .o_rd_data (rd_data)
  );

  pixel_reader pixel_reader_inst (
    .clk        (clk),
    .rst        (rst),
    .i_rd_rdy   (rd_rdy),
    .o_rd_act   (rd_act),
    .i_rd_size  (rd_size),
    .i_rd_data  (rd_data),
    .o_rd_stb   (rd_stb),
    .o_pix      (pix),
    .o_pix_rdy  (pix_rdy),
    .i_pix_stb  (pix_stb),
    .i_tp_valid (i_tp_valid),
    .i_tp_cmd   (i_tp_cmd),
    .o_tp_busy  (o_tp_busy)
  );

  video_timing_gen video_timing_gen_inst (
    .clk         (clk),
    .rst         (rst),
    .i_pix       (pix),
    .i_pix_rdy   (pix_rdy),
    .o_pix_stb   (pix_stb),
    .o_pixel     (o_pixel),
    .o_de        (o_de),
    .o_hsync     (o_hsync),
    .o_vsync     (o_vsync),
    .o_underflow (o_underflow)
  );

endmodule

// ==== video_pkg.sv ====
// pixel word is split evenly into red, green and blue; VID_PIXEL_W must be a multiple of 3
`include "video_config.svh"

package video_pkg;

  // one rgb pixel, red in the top byte
  typedef struct packed {
    logic [`VID_PIXEL_W/3-1:0] red;
    logic [`VID_PIXEL_W/3-1:0] green;
    logic [`VID_PIXEL_W/3-1:0] blue;
  } rgb_pixel_t;

  // test pattern command
  // each enable forces its channel to full scale
  // count is the number of pixels the pattern replaces
  typedef struct packed {
    logic                  red_en;
    logic                  green_en;
    logic                  blue_en;
    logic [`VID_CNT_W-1:0] count;
  } tp_cmd_t;

endpackage

// ==== video_timing_gen.sv ====
// one raster position per clock, no porches; sync outputs are active high
`timescale 1ns/1ps
`include "video_config.svh"

module video_timing_gen (
  input  logic                  clk,
  input  logic                  rst,

  // pixel link
  input  video_pkg::rgb_pixel_t i_pix,
  input  logic                  i_pix_rdy,
  output logic                  o_pix_stb,

  // video out, all registered
  output video_pkg::rgb_pixel_t o_pixel,
  output logic                  o_de,
  output logic                  o_hsync,
  output logic                  o_vsync,

  // sticky until next frame start
  output logic                  o_underflow
);

  localparam int H_TOTAL = `VID_H_ACTIVE + `VID_H_BLANK;
  localparam int V_TOTAL = `VID_V_ACTIVE + `VID_V_BLANK;

  logic [`VID_CNT_W-1:0] h_cnt;
  logic [`VID_CNT_W-1:0] v_cnt;
  logic                  line_end;
  logic                  active;
  logic                  hsync_pos;
  logic                  frame_start;
  logic                  starve;

  assign line_end    = (h_cnt == H_TOTAL - 1);
  assign active      = (h_cnt < `VID_H_ACTIVE) && (v_cnt < `VID_V_ACTIVE);
  // hsync right at the start of horizontal blank
  assign hsync_pos   = (h_cnt >= `VID_H_ACTIVE) &&
                       (h_cnt < `VID_H_ACTIVE + `VID_HSYNC_W);
  assign frame_start = (h_cnt == 0) && (v_cnt == 0);
  // active position and the reader has nothing
  assign starve      = active && !i_pix_rdy;

  // pull one pixel per served active position
  assign o_pix_stb = active && i_pix_rdy;

  // raster counters
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      if (v_cnt == V_TOTAL - 1) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_de        <= 1'b0;
      o_hsync     <= 1'b0;
      o_vsync     <= 1'b0;
      o_underflow <= 1'b0;
    end else begin
      o_de    <= active;
      o_hsync <= hsync_pos;
      // vertical blank lines
      o_vsync <= (v_cnt >= `VID_V_ACTIVE);
      // frame start clears, a starve at that same position still sets
      o_underflow <= (o_underflow && !frame_start) || starve;
    end
  end

  // black on blank and on starved positions
  always_ff @(posedge clk) begin
    if (o_pix_stb) begin
      o_pixel <= i_pix;
    end else begin
      o_pixel <= '0;
    end
  end

endmodule
